//--- rtl/cp0Regs.sv
`timescale 1ns/10ps

module cp0Regs import memStagePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wr,
    input  logic        disWr,
    input  logic [5:0]  interrupt,
    input  exeMemT      memItem,
    input  regsWrT      regsWrFinal,
    input  logic        inDelaySlot,
    input  logic        flushException,
    input  logic        isEret,
    input  excCodeT     excCode,
    output logic [31:0] cp0RdData,
    output logic        statusBev,
    output logic        statusExl,
    output logic        statusIe,
    output logic [7:0]  statusIm,
    output logic [7:0]  causeIp,
    output logic [31:0] epc
);

    logic [4:0]  regNum;
    logic        mtc0En;
    logic        excTake;
    logic        eretTake;
    logic        addrErr;
    logic        causeBd;
    logic [5:0]  causeIpHw;   // IP7..2, hardware lines
    logic [1:0]  causeIpSw;   // IP1..0, software interrupts
    excCodeT     causeExc;
    logic [31:0] badVAddr;

    assign regNum   = memItem.instr[15:11];
    assign mtc0En   = regsWrFinal.cp0Wr & ~disWr & ~flushException;
    // held item commits its exception only once
    assign excTake  = flushException & ~isEret & wr;
    assign eretTake = isEret & wr;
    assign addrErr  = (excCode == excLoadAddr) || (excCode == excStoreAddr);
    assign causeIp  = {causeIpHw, causeIpSw};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusBev <= 1'b1;
            statusIm  <= '0;
            statusExl <= 1'b0;
            statusIe  <= 1'b0;
            causeBd   <= 1'b0;
            causeIpHw <= '0;
            causeIpSw <= '0;
            causeExc  <= excInterrupt;
            epc       <= '0;
            badVAddr  <= '0;
        end else begin
            causeIpHw <= interrupt;  // sampled every cycle
            if (excTake) begin
                statusExl <= 1'b1;
                causeExc  <= excCode;
                causeBd   <= inDelaySlot;
                epc       <= inDelaySlot ? memItem.pc - 32'd4 : memItem.pc;  // point at branch
                if (addrErr) begin
                    badVAddr <= memItem.aluOut;
                end
            end else if (eretTake) begin
                statusExl <= 1'b0;
            end else if (mtc0En) begin
                case (regNum)
                    cp0Status: begin
                        statusBev <= memItem.outB[22];
                        statusIm  <= memItem.outB[15:8];
                        statusExl <= memItem.outB[1];
                        statusIe  <= memItem.outB[0];
                    end
                    cp0Cause: causeIpSw <= memItem.outB[9:8];
                    cp0Epc:   epc       <= memItem.outB;
                    default: ;  // read-only or not present
                endcase
            end
        end
    end

    always_comb begin
        case (regNum)
            cp0BadVAddr: cp0RdData = badVAddr;
            cp0Status:   cp0RdData = {9'b0, statusBev, 6'b0, statusIm, 6'b0, statusExl, statusIe};
            cp0Cause:    cp0RdData = {causeBd, 15'b0, causeIp, 1'b0, causeExc, 2'b0};
            cp0Epc:      cp0RdData = epc;
            default:     cp0RdData = '0;
        endcase
    end

endmodule

//--- rtl/exceptionUnit.sv
`timescale 1ns/10ps

module exceptionUnit import memStagePkg::*; (
    input  exeMemT      memItem,
    input  logic        inDelaySlot,
    input  logic        statusBev,
    input  logic        statusExl,
    input  logic        statusIe,
    input  logic [7:0]  statusIm,
    input  logic [7:0]  causeIp,
    input  logic [31:0] epc,
    output logic        flushException,
    output logic        isEret,
    output excCodeT     excCode,
    output logic [31:0] excVector,
    output regsWrT      regsWrFinal
);

    logic        intPending;
    logic [31:0] excBase;
    exceptFlagsT flags;

    assign flags      = memItem.except;
    assign intPending = statusIe & ~statusExl & (|(causeIp & statusIm));
    assign excBase    = statusBev ? vecBootstrap : vecNormal;

    // fixed priority, interrupt first and eret last
    always_comb begin
        flushException = 1'b1;
        isEret         = 1'b0;
        excCode        = excInterrupt;
        excVector      = excBase;
        if (intPending) begin
            excCode = excInterrupt;
        end else if (flags.reservedInstr) begin
            excCode = excResInstr;
        end else if (flags.overflow) begin
            excCode = excOverflow;
        end else if (flags.syscall) begin
            excCode = excSyscall;
        end else if (flags.brk) begin
            excCode = excBreak;
        end else if (flags.loadAddrErr) begin
            excCode = excLoadAddr;
        end else if (flags.storeAddrErr) begin
            excCode = excStoreAddr;
        end else if (flags.eret) begin
            isEret    = 1'b1;
            excVector = epc;  // return to saved pc
        end else begin
            flushException = 1'b0;
        end
    end

    // the flushed instruction must not write anything
    assign regsWrFinal = flushException ? '0 : memItem.regsWr;

endmodule

//--- rtl/memStage.sv
`timescale 1ns/10ps

module memStage import memStagePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        flush,
    input  logic        wr,
    input  logic        disWr,
    input  logic [5:0]  interrupt,
    input  exeMemT      exeIn,
    output dataReqT     dReq,
    output fwdT         fwd,
    output logic        flushException,
    output logic [31:0] excVector,
    output logic [31:0] epc,
    output logic [31:0] memPc
);

    exeMemT      memItem;
    logic        inDelaySlot;
    regsWrT      regsWrFinal;
    logic [31:0] cp0RdData;
    logic [31:0] operandB;
    logic [31:0] result;
    logic        statusBev;
    logic        statusExl;
    logic        statusIe;
    logic [7:0]  statusIm;
    logic [7:0]  causeIp;
    logic        isEret;
    excCodeT     excCode;

    memStageReg memStageReg_i (
        .clk         (clk),
        .arstN       (arstN),
        .flush       (flush),
        .wr          (wr),
        .exeIn       (exeIn),
        .memItem     (memItem),
        .inDelaySlot (inDelaySlot)
    );

    exceptionUnit exceptionUnit_i (
        .memItem        (memItem),
        .inDelaySlot    (inDelaySlot),
        .statusBev      (statusBev),
        .statusExl      (statusExl),
        .statusIe       (statusIe),
        .statusIm       (statusIm),
        .causeIp        (causeIp),
        .epc            (epc),
        .flushException (flushException),
        .isEret         (isEret),
        .excCode        (excCode),
        .excVector      (excVector),
        .regsWrFinal    (regsWrFinal)
    );

    cp0Regs cp0Regs_i (
        .clk            (clk),
        .arstN          (arstN),
        .wr             (wr),
        .disWr          (disWr),
        .interrupt      (interrupt),
        .memItem        (memItem),
        .regsWrFinal    (regsWrFinal),
        .inDelaySlot    (inDelaySlot),
        .flushException (flushException),
        .isEret         (isEret),
        .excCode        (excCode),
        .cp0RdData      (cp0RdData),
        .statusBev      (statusBev),
        .statusExl      (statusExl),
        .statusIe       (statusIe),
        .statusIm       (statusIm),
        .causeIp        (causeIp),
        .epc            (epc)
    );

    // mfc0 replaces the register operand
    assign operandB = (memItem.readSel == rdCp0) ? cp0RdData : memItem.outB;

    always_comb begin
        case (memItem.wbSel)
            wbRetAddr: result = memItem.pc + 32'd8;  // skip the delay slot
            wbAluOut:  result = memItem.aluOut;
            wbOutB:    result = operandB;
            default:   result = memItem.aluOut;
        endcase
    end

    assign fwd.regsWr = regsWrFinal;
    assign fwd.dst    = memItem.dst;
    assign fwd.result = result;

    // no request for an instruction that is being flushed
    assign dReq.valid  = (memItem.memOp.read | memItem.memOp.write) & ~flushException;
    assign dReq.write  = memItem.memOp.write;
    assign dReq.addr   = memItem.aluOut;
    assign dReq.wdata  = memItem.outB;
    assign dReq.strobe = memItem.memOp.strobe;

    assign memPc = memItem.pc;

endmodule

//--- rtl/memStagePkg.sv
package memStagePkg;

    // forwarded result source
    typedef enum logic [1:0] {
        wbRetAddr = 2'd0,  // pc + 8 for jal/bal
        wbAluOut  = 2'd1,
        wbOutB    = 2'd2
    } wbSelT;

    // where operand B comes from
    typedef enum logic {
        rdRegs = 1'b0,     // register file or HI/LO
        rdCp0  = 1'b1      // mfc0
    } readSelT;

    typedef struct packed {
        logic rfWr;
        logic hiWr;
        logic loWr;
        logic cp0Wr;       // mtc0
    } regsWrT;

    // flags raised upstream
    typedef struct packed {
        logic reservedInstr;
        logic overflow;
        logic syscall;
        logic brk;
        logic loadAddrErr;
        logic storeAddrErr;
        logic eret;
    } exceptFlagsT;

    typedef struct packed {
        logic       read;
        logic       write;
        logic [3:0] strobe;  // byte write enables
    } memOpT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] aluOut;
        logic [31:0] outB;
        logic [4:0]  dst;
        regsWrT      regsWr;
        wbSelT       wbSel;
        readSelT     readSel;
        memOpT       memOp;
        logic        isBranch;
        logic        isJump;
        exceptFlagsT except;
    } exeMemT;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strobe;
    } dataReqT;

    typedef struct packed {
        regsWrT      regsWr;
        logic [4:0]  dst;
        logic [31:0] result;
    } fwdT;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        excInterrupt = 5'd0,
        excLoadAddr  = 5'd4,
        excStoreAddr = 5'd5,
        excSyscall   = 5'd8,
        excBreak     = 5'd9,
        excResInstr  = 5'd10,
        excOverflow  = 5'd12
    } excCodeT;

    localparam logic [4:0] cp0BadVAddr = 5'd8;
    localparam logic [4:0] cp0Status   = 5'd12;
    localparam logic [4:0] cp0Cause    = 5'd13;
    localparam logic [4:0] cp0Epc      = 5'd14;

    localparam logic [31:0] vecNormal    = 32'h8000_0180;
    localparam logic [31:0] vecBootstrap = 32'hBFC0_0380;  // used while BEV is set

endpackage

//--- rtl/memStageReg.sv
`timescale 1ns/10ps

module memStageReg import memStagePkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   flush,
    input  logic   wr,
    input  exeMemT exeIn,
    output exeMemT memItem,
    output logic   inDelaySlot
);

    logic prevIsJump;  // item now held was a branch or jump

    assign prevIsJump = memItem.isBranch | memItem.isJump;

    // flush wins over wr, neither means hold
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memItem <= '0;  // start with a bubble
        end else if (flush) begin
            memItem <= '0;
        end else if (wr) begin
            memItem <= exeIn;
        end
    end

    // the new item follows the old one, so it sits in the old one's delay slot
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inDelaySlot <= 1'b0;
        end else if (flush) begin
            inDelaySlot <= 1'b0;
        end else if (wr) begin
            inDelaySlot <= prevIsJump;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module memStageTb -f sources.f -o memStageSim

# keep the output even when the simulator exits with an error
output=$(./obj_dir/memStageSim 2>&1) || true
echo "$output"

if grep -qx "Simulation passed" <<< "$output"; then
    exit 0
fi
exit 1

//--- sources.f
rtl/memStagePkg.sv
rtl/memStageReg.sv
rtl/exceptionUnit.sv
rtl/cp0Regs.sv
rtl/memStage.sv
verification/memStage_assert.sv
verification/clockGen.sv
verification/memStageTb.sv

//--- verification/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

//--- verification/memStageTb.sv
`timescale 1ns/10ps

module memStageTb import memStagePkg::*; ();

    localparam int numTests      = 5;
    localparam int cyclesPerTest = 400;
    localparam int timeoutCycles = numTests * cyclesPerTest + 500;  // reset plus slack

    logic        clk;
    logic        arstN;
    logic        flush;
    logic        wr;
    logic        disWr;
    logic [5:0]  interrupt;
    exeMemT      exeIn;
    dataReqT     dReq;
    fwdT         fwd;
    logic        flushException;
    logic [31:0] excVector;
    logic [31:0] epc;
    logic [31:0] memPc;

    // reference model
    exeMemT      mItem;
    logic        mDelaySlot;
    logic        mBev;
    logic        mExl;
    logic        mIe;
    logic [7:0]  mIm;
    logic        mBd;
    logic [5:0]  mIpHw;
    logic [1:0]  mIpSw;
    excCodeT     mExcCode;
    logic [31:0] mEpc;
    logic [31:0] mBadVAddr;

    int checkCount;
    int errorCount;
    int cycleCount;

    clockGen clockGen_i (
        .clk   (clk),
        .arstN (arstN)
    );

    memStage dut_i (.*);

    function automatic bit chance(int pct);
        return ($urandom % 100) < pct;
    endfunction

    // mostly the CP0 registers that exist
    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = $urandom;
        case (r[2:0])
            3'd0:       return cp0BadVAddr;
            3'd1, 3'd2: return cp0Status;
            3'd3:       return cp0Cause;
            3'd4, 3'd5: return cp0Epc;
            default:    return r[15:11];
        endcase
    endfunction

    function automatic exeMemT makeItem(int excPct, int cp0Pct);
        exeMemT      it;
        logic [31:0] r;
        r               = $urandom;
        it.pc           = $urandom;
        it.instr        = $urandom;
        it.aluOut       = $urandom;
        it.outB         = $urandom;
        it.instr[15:11] = pickReg();
        it.dst          = r[4:0];
        it.regsWr       = r[8:5];
        it.regsWr.cp0Wr = chance(cp0Pct);
        it.wbSel        = wbSelT'((r[10:9] == 2'd3) ? 2'd2 : r[10:9]);
        it.readSel      = readSelT'(r[11]);
        it.memOp        = r[17:12];
        it.isBranch     = r[18];
        it.isJump       = r[19];
        it.except       = chance(excPct) ? r[26:20] : 7'd0;
        return it;
    endfunction

    // MIPS field layout of the readable registers
    function automatic logic [31:0] cp0Read(logic [4:0] regNum);
        logic [31:0] w;
        w = '0;
        case (regNum)
            cp0BadVAddr: w = mBadVAddr;
            cp0Status: begin
                w[22]   = mBev;
                w[15:8] = mIm;
                w[1]    = mExl;
                w[0]    = mIe;
            end
            cp0Cause: begin
                w[31]   = mBd;
                w[15:8] = {mIpHw, mIpSw};
                w[6:2]  = mExcCode;
            end
            cp0Epc:  w = mEpc;
            default: ;
        endcase
        return w;
    endfunction

    task automatic evalException(output logic taken, output logic eretOnly, output excCodeT code);
        exceptFlagsT f;
        logic        intReq;
        f        = mItem.except;
        intReq   = mIe && !mExl && (({mIpHw, mIpSw} & mIm) != 8'd0);
        taken    = 1'b1;
        eretOnly = 1'b0;
        code     = excInterrupt;
        if (intReq)               code = excInterrupt;
        else if (f.reservedInstr) code = excResInstr;
        else if (f.overflow)      code = excOverflow;
        else if (f.syscall)       code = excSyscall;
        else if (f.brk)           code = excBreak;
        else if (f.loadAddrErr)   code = excLoadAddr;
        else if (f.storeAddrErr)  code = excStoreAddr;
        else if (f.eret)          eretOnly = 1'b1;
        else                      taken = 1'b0;
    endtask

    // one clock edge, using the inputs that were applied before it
    task automatic updateModel();
        logic    taken;
        logic    eretOnly;
        excCodeT code;
        evalException(taken, eretOnly, code);
        if (taken && !eretOnly && wr) begin
            mExl     = 1'b1;
            mExcCode = code;
            mBd      = mDelaySlot;
            mEpc     = mDelaySlot ? mItem.pc - 32'd4 : mItem.pc;
            if (code == excLoadAddr || code == excStoreAddr) mBadVAddr = mItem.aluOut;
        end else if (eretOnly && wr) begin
            mExl = 1'b0;
        end else if (!taken && mItem.regsWr.cp0Wr && !disWr) begin
            case (mItem.instr[15:11])
                cp0Status: begin
                    mBev = mItem.outB[22];
                    mIm  = mItem.outB[15:8];
                    mExl = mItem.outB[1];
                    mIe  = mItem.outB[0];
                end
                cp0Cause: mIpSw = mItem.outB[9:8];
                cp0Epc:   mEpc = mItem.outB;
                default:  ;
            endcase
        end
        mIpHw = interrupt;
        if (flush) begin
            mItem      = '0;
            mDelaySlot = 1'b0;
        end else if (wr) begin
            mDelaySlot = mItem.isBranch | mItem.isJump;
            mItem      = exeIn;
        end
    endtask

    task automatic checkFwd(fwdT exp, fwdT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: fwd expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic checkReq(dataReqT exp, dataReqT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: dReq expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic checkExc(logic expFlush, logic [31:0] expVector, logic [31:0] expEpc,
                            logic actFlush, logic [31:0] actVector, logic [31:0] actEpc);
        checkCount++;
        // vector only matters while flushing
        if (actFlush !== expFlush || actEpc !== expEpc || (expFlush && actVector !== expVector))
        begin
            errorCount++;
            $display("MISMATCH at %0t: flush/vector/epc expected %b %h %h got %b %h %h",
                     $time, expFlush, expVector, expEpc, actFlush, actVector, actEpc);
        end
    endtask

    task automatic checkPc(logic [31:0] exp, logic [31:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: memPc expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic checkOutputs();
        logic        taken;
        logic        eretOnly;
        excCodeT     code;
        fwdT         expFwd;
        dataReqT     expReq;
        logic [31:0] opB;
        logic [31:0] vec;
        evalException(taken, eretOnly, code);
        opB = (mItem.readSel == rdCp0) ? cp0Read(mItem.instr[15:11]) : mItem.outB;
        expFwd.regsWr = taken ? '0 : mItem.regsWr;
        expFwd.dst    = mItem.dst;
        case (mItem.wbSel)
            wbRetAddr: expFwd.result = mItem.pc + 32'd8;
            wbAluOut:  expFwd.result = mItem.aluOut;
            default:   expFwd.result = opB;
        endcase
        expReq.valid  = (mItem.memOp.read || mItem.memOp.write) && !taken;
        expReq.write  = mItem.memOp.write;
        expReq.addr   = mItem.aluOut;
        expReq.wdata  = mItem.outB;
        expReq.strobe = mItem.memOp.strobe;
        vec = eretOnly ? mEpc : (mBev ? 32'hBFC0_0380 : 32'h8000_0180);
        checkPc(mItem.pc, memPc);
        checkFwd(expFwd, fwd);
        checkReq(expReq, dReq);
        checkExc(taken, vec, mEpc, flushException, excVector, epc);
    endtask

    task automatic runTest(int num, string name, int wrPct, int flushPct, int excPct,
                           int cp0Pct, int disPct, int intPct);
        int          errorsBefore;
        int          checksBefore;
        logic [31:0] r;
        errorsBefore = errorCount;
        checksBefore = checkCount;
        repeat (cyclesPerTest) begin
            @(posedge clk);
            #10;
            updateModel();
            checkOutputs();
            r         = $urandom;
            wr        = chance(wrPct);
            flush     = chance(flushPct);
            disWr     = chance(disPct);
            interrupt = chance(intPct) ? r[5:0] : 6'd0;
            exeIn     = makeItem(excPct, cp0Pct);
        end
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checkCount - checksBefore, errorCount - errorsBefore);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("ERROR: run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h7217cd7a));
        flush      = 1'b0;
        wr         = 1'b0;
        disWr      = 1'b0;
        interrupt  = '0;
        exeIn      = '0;
        mItem      = '0;  // reset state of the stage
        mDelaySlot = 1'b0;
        mBev       = 1'b1;
        mExl       = 1'b0;
        mIe        = 1'b0;
        mIm        = '0;
        mBd        = 1'b0;
        mIpHw      = '0;
        mIpSw      = '0;
        mExcCode   = excInterrupt;
        mEpc       = '0;
        mBadVAddr  = '0;
        @(posedge arstN);
        runTest(1, "pipeline register", 60, 20, 10, 10, 20, 20);
        runTest(2, "forwarding", 85, 5, 0, 30, 20, 10);
        runTest(3, "exception priority", 80, 5, 60, 10, 10, 20);
        runTest(4, "cp0 update", 75, 10, 20, 50, 30, 20);
        runTest(5, "interrupts", 80, 5, 15, 50, 10, 60);
        $display("total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verification/memStage_assert.sv
`timescale 1ns/10ps

module memStage_assert import memStagePkg::*; (
    input logic    clk,
    input logic    arstN,
    input logic    flush,
    input logic    wr,
    input logic    flushException,
    input logic    isEret,
    input logic    statusExl,
    input dataReqT dReq,
    input fwdT     fwd
);

    // bubble loaded by the flush never reaches memory
    bubbleNoReq: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> !dReq.valid)
        else $error("data request issued in the cycle after a pipeline flush");

    // committed exception enters exception level
    excSetsExl: assert property (@(posedge clk) disable iff (!arstN)
        (flushException && !isEret && wr) |=> statusExl)
        else $error("exception committed without setting Status.EXL");

    // bubble loaded by the flush
    bubbleNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> fwd.regsWr == '0)
        else $error("register write enabled in the cycle after a pipeline flush");

endmodule

bind memStage memStage_assert memStageAssert_i (
    .clk            (clk),
    .arstN          (arstN),
    .flush          (flush),
    .wr             (wr),
    .flushException (flushException),
    .isEret         (isEret),
    .statusExl      (statusExl),
    .dReq           (dReq),
    .fwd            (fwd)
);
